//--- common/epu_params.svh
`ifndef EPU_PARAMS_SVH
`define EPU_PARAMS_SVH

// Datapath and bus widths
`define EPU_DATA_BITS 32
`define EPU_ADDR_BITS 32

// Buffer geometry, word index is taken from address bits 9:2
`define EPU_BUF_DEPTH 256
`define EPU_IDX_BITS  8

// Address map, each region spans 16 MB above its base
`define EPU_REGION_MASK 32'hFF00_0000
`define EPU_IN_BASE     32'h5000_0000
`define EPU_OUT_BASE    32'h6000_0000
`define EPU_WGT_BASE    32'h7000_0000
`define EPU_CTRL_BASE   32'h8000_0000

// Register offsets inside the control region
`define EPU_REG_CTRL   4'h0
`define EPU_REG_LEN    4'h4
`define EPU_REG_TAPS   4'h8
`define EPU_REG_STATUS 4'hC

`endif

//--- common/axi_pkg.sv
`default_nettype none

`include "epu_params.svh"

package axi_pkg;

  typedef logic [`EPU_ADDR_BITS-1:0] addr_t;
  typedef logic [`EPU_DATA_BITS-1:0] data_t;
  typedef logic [3:0]                id_t;
  typedef logic [7:0]                len_t;
  typedef logic [1:0]                resp_t;

  localparam resp_t RESP_OKAY = 2'b00;

  // Fields driven by the master
  typedef struct packed {
    logic  awvalid;
    addr_t awaddr;
    id_t   awid;
    len_t  awlen;
    logic  wvalid;
    data_t wdata;
    logic  wlast;
    logic  bready;
    logic  arvalid;
    addr_t araddr;
    id_t   arid;
    len_t  arlen;
    logic  rready;
  } axi_req_t;

  // Fields driven by the slave
  typedef struct packed {
    logic  awready;
    logic  wready;
    logic  bvalid;
    id_t   bid;
    resp_t bresp;
    logic  arready;
    logic  rvalid;
    id_t   rid;
    data_t rdata;
    resp_t rresp;
    logic  rlast;
  } axi_rsp_t;

endpackage

`default_nettype wire

//--- common/epu_pkg.sv
`default_nettype none

`include "epu_params.svh"

package epu_pkg;

  typedef logic [`EPU_IDX_BITS-1:0] word_idx_t;

  // One-hot target select from the address decoder
  typedef enum logic [4:0] {
    REGION_NONE = 5'b00001,
    REGION_IN   = 5'b00010,
    REGION_OUT  = 5'b00100,
    REGION_WGT  = 5'b01000,
    REGION_CTRL = 5'b10000
  } region_e;

  // A single access to one word buffer
  typedef struct packed {
    logic          en;
    logic          we;
    word_idx_t     idx;
    axi_pkg::data_t wdata;
  } buf_port_t;

  // Engine setup, stable while the engine runs
  typedef struct packed {
    logic [7:0] len;
    logic [7:0] taps;
    logic       relu;
  } conv_cfg_t;

endpackage

`default_nettype wire

//--- hdl/epu_slave_port.sv
`timescale 1ns/1ps
`default_nettype none

`include "epu_params.svh"

module epu_slave_port (
  input  logic                clk,
  input  logic                rst,
  input  axi_pkg::axi_req_t   axi_req_i,
  output axi_pkg::axi_rsp_t   axi_rsp_o,
  output epu_pkg::buf_port_t  bus_port_o,
  output epu_pkg::region_e    region_o,
  output logic [1:0]          reg_addr_o,
  input  axi_pkg::data_t      in_rdata_i,
  input  axi_pkg::data_t      out_rdata_i,
  input  axi_pkg::data_t      wgt_rdata_i,
  input  axi_pkg::data_t      reg_rdata_i
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_RD,
    ST_WR,
    ST_RESP
  } state_e;

  state_e             state_q;
  epu_pkg::region_e   region_q;
  epu_pkg::region_e   ar_region;
  axi_pkg::id_t       id_q;
  axi_pkg::len_t      len_q;
  axi_pkg::len_t      cnt_q;
  epu_pkg::word_idx_t idx_q;
  logic               aw_hs, ar_hs, w_hs, r_hs, b_hs;
  logic               last_beat;

  function automatic epu_pkg::region_e decode_region(axi_pkg::addr_t addr);
    axi_pkg::addr_t blk;
    blk = addr & `EPU_REGION_MASK;
    case (blk)
      `EPU_IN_BASE:   return epu_pkg::REGION_IN;
      `EPU_OUT_BASE:  return epu_pkg::REGION_OUT;
      `EPU_WGT_BASE:  return epu_pkg::REGION_WGT;
      `EPU_CTRL_BASE: return epu_pkg::REGION_CTRL;
      default:        return epu_pkg::REGION_NONE;
    endcase
  endfunction

  // AW wins over AR when both arrive in IDLE
  assign aw_hs     = axi_req_i.awvalid && (state_q == ST_IDLE);
  assign ar_hs     = axi_req_i.arvalid && !axi_req_i.awvalid && (state_q == ST_IDLE);
  assign w_hs      = axi_req_i.wvalid && (state_q == ST_WR);
  assign r_hs      = axi_req_i.rready && (state_q == ST_RD);
  assign b_hs      = axi_req_i.bready && (state_q == ST_RESP);
  assign last_beat = (cnt_q == len_q);
  assign ar_region = decode_region(axi_req_i.araddr);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state_q  <= ST_IDLE;
      region_q <= epu_pkg::REGION_NONE;
      id_q     <= '0;
      len_q    <= '0;
      cnt_q    <= '0;
      idx_q    <= '0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          cnt_q <= '0;
          if (aw_hs) begin
            state_q  <= ST_WR;
            region_q <= decode_region(axi_req_i.awaddr);
            id_q     <= axi_req_i.awid;
            len_q    <= axi_req_i.awlen;
            idx_q    <= axi_req_i.awaddr[`EPU_IDX_BITS+1:2];
          end else if (ar_hs) begin
            // First word is already being read so idx_q points at the second
            state_q  <= ST_RD;
            region_q <= ar_region;
            id_q     <= axi_req_i.arid;
            len_q    <= axi_req_i.arlen;
            idx_q    <= axi_req_i.araddr[`EPU_IDX_BITS+1:2] + 1'b1;
          end
        end
        ST_WR: begin
          if (w_hs) begin
            idx_q <= idx_q + 1'b1;
            cnt_q <= cnt_q + 1'b1;
            if (axi_req_i.wlast) state_q <= ST_RESP;
          end
        end
        ST_RD: begin
          if (r_hs) begin
            idx_q <= idx_q + 1'b1;
            cnt_q <= cnt_q + 1'b1;
            if (last_beat) state_q <= ST_IDLE;
          end
        end
        ST_RESP: begin
          if (b_hs) state_q <= ST_IDLE;
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // The region select routes the enable of the shared buffer port
  always_comb begin
    bus_port_o = '0;
    region_o   = region_q;
    case (state_q)
      ST_IDLE: begin
        bus_port_o.en  = ar_hs;
        bus_port_o.idx = axi_req_i.araddr[`EPU_IDX_BITS+1:2];
        region_o       = ar_hs ? ar_region : epu_pkg::REGION_NONE;
      end
      ST_WR: begin
        bus_port_o.en    = w_hs;
        bus_port_o.we    = 1'b1;
        bus_port_o.idx   = idx_q;
        bus_port_o.wdata = axi_req_i.wdata;
      end
      ST_RD: begin
        // Next word is fetched on each handshake so beats run back to back
        bus_port_o.en  = r_hs && !last_beat;
        bus_port_o.idx = idx_q;
      end
      default: bus_port_o = '0;
    endcase
  end

  // Word index bits 1:0 are address bits 3:2
  assign reg_addr_o = bus_port_o.idx[1:0];

  always_comb begin
    axi_rsp_o         = '0;
    axi_rsp_o.awready = (state_q == ST_IDLE);
    axi_rsp_o.arready = (state_q == ST_IDLE) && !axi_req_i.awvalid;
    axi_rsp_o.wready  = (state_q == ST_WR);
    axi_rsp_o.bvalid  = (state_q == ST_RESP);
    axi_rsp_o.bid     = id_q;
    axi_rsp_o.bresp   = axi_pkg::RESP_OKAY;
    axi_rsp_o.rvalid  = (state_q == ST_RD);
    axi_rsp_o.rid     = id_q;
    axi_rsp_o.rresp   = axi_pkg::RESP_OKAY;
    axi_rsp_o.rlast   = (state_q == ST_RD) && last_beat;
    case (region_q)
      epu_pkg::REGION_IN:   axi_rsp_o.rdata = in_rdata_i;
      epu_pkg::REGION_OUT:  axi_rsp_o.rdata = out_rdata_i;
      epu_pkg::REGION_WGT:  axi_rsp_o.rdata = wgt_rdata_i;
      epu_pkg::REGION_CTRL: axi_rsp_o.rdata = reg_rdata_i;
      default:              axi_rsp_o.rdata = '0;
    endcase
  end

  // W data only follows an accepted AW, inside the write burst
  a_w_in_write: assert property (@(posedge clk) disable iff (rst)
    axi_req_i.wvalid |-> state_q == ST_WR)
    else $error("wvalid raised outside the write state");

endmodule

`default_nettype wire

//--- hdl/epu_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "epu_params.svh"

module epu_buffer #(
  parameter int DEPTH = `EPU_BUF_DEPTH
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               engine_busy_i,
  input  epu_pkg::buf_port_t bus_port_i,
  input  epu_pkg::buf_port_t engine_port_i,
  output axi_pkg::data_t     rdata_o
);

  axi_pkg::data_t     mem [DEPTH];
  epu_pkg::buf_port_t port;

  // Engine owns the RAM for the whole run
  assign port = engine_busy_i ? engine_port_i : bus_port_i;

  // Read data holds between accesses, the slave relies on it during stalls
  always_ff @(posedge clk) begin
    if (port.en) begin
      if (port.we) begin
        mem[port.idx] <= port.wdata;
      end else begin
        rdata_o <= mem[port.idx];
      end
    end
  end

  a_no_bus_when_busy: assert property (@(posedge clk) disable iff (rst)
    engine_busy_i |-> !bus_port_i.en)
    else $error("bus access to a buffer while the engine is busy");

endmodule

`default_nettype wire

//--- hdl/epu_ctrl_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "epu_params.svh"

module epu_ctrl_regs (
  input  logic               clk,
  input  logic               rst,
  input  logic               wr_i,
  input  logic               rd_i,
  input  logic [1:0]         reg_addr_i,
  input  axi_pkg::data_t     wdata_i,
  input  logic               busy_i,
  input  logic               done_i,
  output axi_pkg::data_t     rdata_o,
  output epu_pkg::conv_cfg_t cfg_o,
  output logic               start_o,
  output logic               irq_o
);

  localparam logic [3:0] OFF_CTRL   = `EPU_REG_CTRL;
  localparam logic [3:0] OFF_LEN    = `EPU_REG_LEN;
  localparam logic [3:0] OFF_TAPS   = `EPU_REG_TAPS;
  localparam logic [3:0] OFF_STATUS = `EPU_REG_STATUS;

  logic [7:0] len_q, taps_q;
  logic       relu_q, start_q, done_q;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      len_q   <= '0;
      taps_q  <= '0;
      relu_q  <= 1'b0;
      start_q <= 1'b0;
      done_q  <= 1'b0;
    end else begin
      start_q <= 1'b0;
      if (wr_i) begin
        case (reg_addr_i)
          OFF_CTRL[3:2]: begin
            // Config is frozen while a run is in progress
            if (!busy_i) begin
              start_q <= wdata_i[0];
              relu_q  <= wdata_i[1];
            end
            done_q <= 1'b0;
          end
          OFF_LEN[3:2]:  if (!busy_i) len_q <= wdata_i[7:0];
          OFF_TAPS[3:2]: if (!busy_i) taps_q <= wdata_i[7:0];
          default: ;
        endcase
      end
      // A new done pulse beats a clear in the same cycle
      if (done_i) done_q <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_i) begin
      case (reg_addr_i)
        OFF_CTRL[3:2]:   rdata_o <= axi_pkg::data_t'({relu_q, 1'b0});
        OFF_LEN[3:2]:    rdata_o <= axi_pkg::data_t'(len_q);
        OFF_TAPS[3:2]:   rdata_o <= axi_pkg::data_t'(taps_q);
        OFF_STATUS[3:2]: rdata_o <= axi_pkg::data_t'({done_q, busy_i});
        default:         rdata_o <= '0;
      endcase
    end
  end

  assign cfg_o   = '{len: len_q, taps: taps_q, relu: relu_q};
  assign start_o = start_q;
  assign irq_o   = done_q;

endmodule

`default_nettype wire

//--- conv_acc/conv_acc_engine.sv
`timescale 1ns/1ps
`default_nettype none

module conv_acc_engine (
  input  logic               clk,
  input  logic               rst,
  input  logic               start_i,
  input  epu_pkg::conv_cfg_t cfg_i,
  input  axi_pkg::data_t     in_rdata_i,
  input  axi_pkg::data_t     wgt_rdata_i,
  output epu_pkg::buf_port_t in_port_o,
  output epu_pkg::buf_port_t wgt_port_o,
  output epu_pkg::buf_port_t out_port_o,
  output logic               busy_o,
  output logic               done_o
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_FETCH,
    ST_DRAIN,
    ST_WRITE
  } state_e;

  state_e             state_q;
  epu_pkg::word_idx_t o_q, k_q;
  axi_pkg::data_t     acc_q, result;
  logic signed [15:0] prod;
  logic               pend_q, done_q, last_tap, last_out, no_taps;

  assign last_tap = (k_q == cfg_i.taps - 8'd1);
  assign last_out = (o_q == cfg_i.len - 8'd1);
  assign no_taps  = (cfg_i.taps == 8'd0);
  assign prod     = $signed(in_rdata_i[7:0]) * $signed(wgt_rdata_i[7:0]);
  assign result   = (cfg_i.relu && acc_q[31]) ? '0 : acc_q;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state_q <= ST_IDLE;
      o_q     <= '0;
      k_q     <= '0;
      acc_q   <= '0;
      pend_q  <= 1'b0;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      // Data of the read issued last cycle is on the RAM outputs now
      pend_q <= (state_q == ST_FETCH);
      if (pend_q) acc_q <= acc_q + {{16{prod[15]}}, prod};
      case (state_q)
        ST_IDLE: begin
          if (start_i) begin
            o_q   <= '0;
            k_q   <= '0;
            acc_q <= '0;
            if (cfg_i.len == 8'd0) done_q <= 1'b1;
            else state_q <= no_taps ? ST_WRITE : ST_FETCH;
          end
        end
        ST_FETCH: begin
          k_q <= k_q + 1'b1;
          if (last_tap) begin
            k_q     <= '0;
            state_q <= ST_DRAIN;
          end
        end
        // Last product lands during this cycle
        ST_DRAIN: state_q <= ST_WRITE;
        ST_WRITE: begin
          acc_q <= '0;
          o_q   <= o_q + 1'b1;
          if (last_out) begin
            state_q <= ST_IDLE;
            done_q  <= 1'b1;
          end else begin
            state_q <= no_taps ? ST_WRITE : ST_FETCH;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  always_comb begin
    in_port_o        = '0;
    wgt_port_o       = '0;
    out_port_o       = '0;
    in_port_o.en     = (state_q == ST_FETCH);
    in_port_o.idx    = o_q + k_q;
    wgt_port_o.en    = (state_q == ST_FETCH);
    wgt_port_o.idx   = k_q;
    out_port_o.en    = (state_q == ST_WRITE);
    out_port_o.we    = 1'b1;
    out_port_o.idx   = o_q;
    out_port_o.wdata = result;
  end

  assign busy_o = (state_q != ST_IDLE);
  assign done_o = done_q;

  a_no_start_busy: assert property (@(posedge clk) disable iff (rst)
    start_i |-> state_q == ST_IDLE)
    else $error("start pulse while the engine is running");

endmodule

`default_nettype wire

//--- hdl/epu_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "epu_params.svh"

module epu_top (
  input  logic              clk,
  input  logic              rst,
  input  axi_pkg::axi_req_t axi_req_i,
  output axi_pkg::axi_rsp_t axi_rsp_o,
  output logic              irq_o
);

  epu_pkg::buf_port_t bus_port, in_bus, wgt_bus, out_bus;
  epu_pkg::buf_port_t in_eng, wgt_eng, out_eng;
  epu_pkg::region_e   region;
  epu_pkg::conv_cfg_t cfg;
  logic [1:0]         reg_addr;
  axi_pkg::data_t     in_rdata, out_rdata, wgt_rdata, reg_rdata;
  logic               start, engine_busy, engine_done, reg_wr, reg_rd;

  // Each target sees the shared bus port only when it is selected
  always_comb begin
    in_bus     = bus_port;
    wgt_bus    = bus_port;
    out_bus    = bus_port;
    in_bus.en  = bus_port.en && (region == epu_pkg::REGION_IN);
    wgt_bus.en = bus_port.en && (region == epu_pkg::REGION_WGT);
    out_bus.en = bus_port.en && (region == epu_pkg::REGION_OUT);
  end

  assign reg_wr = bus_port.en && bus_port.we && (region == epu_pkg::REGION_CTRL);
  assign reg_rd = bus_port.en && !bus_port.we && (region == epu_pkg::REGION_CTRL);

  epu_slave_port u_slave (
    .clk         (clk),
    .rst         (rst),
    .axi_req_i   (axi_req_i),
    .axi_rsp_o   (axi_rsp_o),
    .bus_port_o  (bus_port),
    .region_o    (region),
    .reg_addr_o  (reg_addr),
    .in_rdata_i  (in_rdata),
    .out_rdata_i (out_rdata),
    .wgt_rdata_i (wgt_rdata),
    .reg_rdata_i (reg_rdata)
  );

  epu_buffer #(.DEPTH(`EPU_BUF_DEPTH)) u_in_buf (
    .clk(clk), .rst(rst), .engine_busy_i(engine_busy),
    .bus_port_i(in_bus), .engine_port_i(in_eng), .rdata_o(in_rdata)
  );

  epu_buffer #(.DEPTH(`EPU_BUF_DEPTH)) u_wgt_buf (
    .clk(clk), .rst(rst), .engine_busy_i(engine_busy),
    .bus_port_i(wgt_bus), .engine_port_i(wgt_eng), .rdata_o(wgt_rdata)
  );

  epu_buffer #(.DEPTH(`EPU_BUF_DEPTH)) u_out_buf (
    .clk(clk), .rst(rst), .engine_busy_i(engine_busy),
    .bus_port_i(out_bus), .engine_port_i(out_eng), .rdata_o(out_rdata)
  );

  epu_ctrl_regs u_regs (
    .clk        (clk),
    .rst        (rst),
    .wr_i       (reg_wr),
    .rd_i       (reg_rd),
    .reg_addr_i (reg_addr),
    .wdata_i    (bus_port.wdata),
    .busy_i     (engine_busy),
    .done_i     (engine_done),
    .rdata_o    (reg_rdata),
    .cfg_o      (cfg),
    .start_o    (start),
    .irq_o      (irq_o)
  );

  conv_acc_engine u_engine (
    .clk         (clk),
    .rst         (rst),
    .start_i     (start),
    .cfg_i       (cfg),
    .in_rdata_i  (in_rdata),
    .wgt_rdata_i (wgt_rdata),
    .in_port_o   (in_eng),
    .wgt_port_o  (wgt_eng),
    .out_port_o  (out_eng),
    .busy_o      (engine_busy),
    .done_o      (engine_done)
  );

endmodule

`default_nettype wire

//--- tests/epu_checker.sv
`timescale 1ns/1ps
`default_nettype none

module epu_checker (
  input  logic              clk,
  input  logic              rst,
  input  axi_pkg::axi_req_t axi_req_i,
  input  axi_pkg::axi_rsp_t axi_rsp_i,
  input  logic              irq_i,
  input  logic              exp_push_i,
  input  axi_pkg::data_t    exp_data_i,
  input  axi_pkg::id_t      exp_id_i,
  input  logic              exp_last_i,
  input  logic              irq_check_i,
  input  logic              irq_exp_i,
  output int                err_cnt_o,
  output int                beat_cnt_o,
  output int                pending_o
);

  axi_pkg::data_t exp_data_q [$];
  axi_pkg::id_t   exp_id_q [$];
  logic           exp_last_q [$];
  axi_pkg::id_t   aw_id_q;
  logic           stall_q;
  axi_pkg::data_t stall_data_q;

  task automatic check_hex(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
      err_cnt_o++;
    end
  endtask

  // Sampled mid-cycle, so every valid/ready pair seen here completes on the next rising edge
  always @(negedge clk) begin
    if (rst) begin
      err_cnt_o  = 0;
      beat_cnt_o = 0;
      stall_q    = 1'b0;
      aw_id_q    = '0;
      exp_data_q.delete();
      exp_id_q.delete();
      exp_last_q.delete();
    end else begin
      if (exp_push_i) begin
        exp_data_q.push_back(exp_data_i);
        exp_id_q.push_back(exp_id_i);
        exp_last_q.push_back(exp_last_i);
      end
      if (axi_req_i.awvalid && axi_rsp_i.awready) aw_id_q = axi_req_i.awid;
      if (axi_rsp_i.bvalid && axi_req_i.bready) begin
        check_hex("bid", 32'(axi_rsp_i.bid), 32'(aw_id_q));
        check_hex("bresp", 32'(axi_rsp_i.bresp), 32'(axi_pkg::RESP_OKAY));
      end
      // A stalled beat must stay on the bus unchanged
      if (stall_q && !(axi_rsp_i.rvalid && axi_rsp_i.rdata === stall_data_q)) begin
        $display("R beat dropped or changed while rready was low");
        err_cnt_o++;
      end
      stall_q      = axi_rsp_i.rvalid && !axi_req_i.rready;
      stall_data_q = axi_rsp_i.rdata;
      if (axi_rsp_i.rvalid && axi_req_i.rready) begin
        beat_cnt_o++;
        if (exp_data_q.size() == 0) begin
          $display("R beat arrived with no expected value queued");
          err_cnt_o++;
        end else begin
          check_hex("rdata", axi_rsp_i.rdata, exp_data_q.pop_front());
          check_hex("rid", 32'(axi_rsp_i.rid), 32'(exp_id_q.pop_front()));
          check_hex("rlast", 32'(axi_rsp_i.rlast), 32'(exp_last_q.pop_front()));
          check_hex("rresp", 32'(axi_rsp_i.rresp), 32'(axi_pkg::RESP_OKAY));
        end
      end
      if (irq_check_i) check_hex("irq_o", 32'(irq_i), 32'(irq_exp_i));
    end
    pending_o = exp_data_q.size();
  end

endmodule

`default_nettype wire

//--- tests/epu_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "epu_params.svh"

module epu_tb;

  localparam int TIMEOUT = 2000;

  logic              clk;
  logic              rst;
  axi_pkg::axi_req_t req;
  axi_pkg::axi_rsp_t rsp;
  logic              irq;
  logic              exp_push, exp_last, irq_check, irq_exp;
  axi_pkg::data_t    exp_data;
  axi_pkg::id_t      exp_id;
  int                err_cnt, beat_cnt, pending, timeouts;
  logic [31:0]       lfsr;
  axi_pkg::data_t    wr_data [$];
  axi_pkg::data_t    rd_exp [$];
  axi_pkg::data_t    in_words [$];
  axi_pkg::data_t    wgt_words [$];

  always #5 clk = ~clk;

  epu_top dut (
    .clk       (clk),
    .rst       (rst),
    .axi_req_i (req),
    .axi_rsp_o (rsp),
    .irq_o     (irq)
  );

  epu_checker chk (
    .clk         (clk),
    .rst         (rst),
    .axi_req_i   (req),
    .axi_rsp_i   (rsp),
    .irq_i       (irq),
    .exp_push_i  (exp_push),
    .exp_data_i  (exp_data),
    .exp_id_i    (exp_id),
    .exp_last_i  (exp_last),
    .irq_check_i (irq_check),
    .irq_exp_i   (irq_exp),
    .err_cnt_o   (err_cnt),
    .beat_cnt_o  (beat_cnt),
    .pending_o   (pending)
  );

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step per bit handed out
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    int          i;
    v = '0;
    for (i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // Sum of sign-extended low-byte products, optionally clamped at zero
  function automatic axi_pkg::data_t conv_ref(input int o, input int taps, input logic relu);
    int                sum;
    int                k;
    logic signed [7:0] a;
    logic signed [7:0] b;
    sum = 0;
    for (k = 0; k < taps; k++) begin
      a   = in_words[o + k][7:0];
      b   = wgt_words[k][7:0];
      sum = sum + int'(a) * int'(b);
    end
    if (relu && sum < 0) sum = 0;
    return axi_pkg::data_t'(sum);
  endfunction

  task automatic wait_flag(input string name);
    int   cycles;
    logic seen;
    cycles = 0;
    seen   = 1'b0;
    while (!seen && cycles < TIMEOUT) begin
      @(negedge clk);
      if (name == "awready") seen = rsp.awready;
      else if (name == "wready") seen = rsp.wready;
      else if (name == "bvalid") seen = rsp.bvalid;
      else if (name == "arready") seen = rsp.arready;
      else seen = irq;
      cycles++;
    end
    if (!seen) begin
      $display("Timeout after %0d cycles waiting for %s", TIMEOUT, name);
      timeouts++;
    end
  endtask

  task automatic axi_write(input axi_pkg::addr_t addr, input axi_pkg::id_t id);
    int i;
    @(posedge clk);
    req.awvalid <= 1'b1;
    req.awaddr  <= addr;
    req.awid    <= id;
    req.awlen   <= axi_pkg::len_t'(wr_data.size() - 1);
    wait_flag("awready");
    @(posedge clk);
    req.awvalid <= 1'b0;
    for (i = 0; i < wr_data.size(); i++) begin
      req.wvalid <= 1'b1;
      req.wdata  <= wr_data[i];
      req.wlast  <= (i == wr_data.size() - 1);
      wait_flag("wready");
      @(posedge clk);
    end
    req.wvalid <= 1'b0;
    req.wlast  <= 1'b0;
    req.bready <= 1'b1;
    wait_flag("bvalid");
    @(posedge clk);
    req.bready <= 1'b0;
  endtask

  // Hands the expected beats to the checker, one per cycle
  task automatic push_expect(input axi_pkg::id_t id);
    int i;
    for (i = 0; i < rd_exp.size(); i++) begin
      @(posedge clk);
      exp_push <= 1'b1;
      exp_data <= rd_exp[i];
      exp_id   <= id;
      exp_last <= (i == rd_exp.size() - 1);
    end
    @(posedge clk);
    exp_push <= 1'b0;
  endtask

  task automatic axi_read(input axi_pkg::addr_t addr, input axi_pkg::id_t id);
    int beats;
    int cycles;
    push_expect(id);
    req.arvalid <= 1'b1;
    req.araddr  <= addr;
    req.arid    <= id;
    req.arlen   <= axi_pkg::len_t'(rd_exp.size() - 1);
    wait_flag("arready");
    @(posedge clk);
    req.arvalid <= 1'b0;
    beats  = 0;
    cycles = 0;
    // Roughly one cycle in four stalls the R channel
    while (beats < rd_exp.size() && cycles < TIMEOUT) begin
      req.rready <= (rand_bits(2) != 32'd0);
      @(negedge clk);
      if (rsp.rvalid && req.rready) beats++;
      @(posedge clk);
      cycles++;
    end
    req.rready <= 1'b0;
    if (beats < rd_exp.size()) begin
      $display("Timeout on read burst at 0x%h after %0d of %0d beats", addr, beats,
               rd_exp.size());
      timeouts++;
    end
  endtask

  task automatic reg_write(input logic [3:0] off, input axi_pkg::data_t val);
    wr_data.delete();
    wr_data.push_back(val);
    axi_write(`EPU_CTRL_BASE | {28'd0, off}, 4'h1);
  endtask

  task automatic reg_read(input logic [3:0] off, input axi_pkg::data_t exp);
    rd_exp.delete();
    rd_exp.push_back(exp);
    axi_read(`EPU_CTRL_BASE | {28'd0, off}, 4'h2);
  endtask

  task automatic check_irq_level(input logic level);
    @(posedge clk);
    irq_check <= 1'b1;
    irq_exp   <= level;
    @(posedge clk);
    irq_check <= 1'b0;
  endtask

  task automatic run_conv(input logic relu);
    int len;
    int taps;
    int i;
    len  = 1 + int'(rand_bits(4));
    taps = 1 + int'(rand_bits(3));
    in_words.delete();
    wgt_words.delete();
    for (i = 0; i < len + taps - 1; i++) in_words.push_back(rand_bits(32));
    for (i = 0; i < taps; i++) wgt_words.push_back(rand_bits(32));
    wr_data = in_words;
    axi_write(`EPU_IN_BASE, 4'h3);
    wr_data = wgt_words;
    axi_write(`EPU_WGT_BASE, 4'h4);
    reg_write(`EPU_REG_LEN, 32'(len));
    reg_write(`EPU_REG_TAPS, 32'(taps));
    reg_write(`EPU_REG_CTRL, {30'd0, relu, 1'b1});
    wait_flag("irq_o");
    rd_exp.delete();
    for (i = 0; i < len; i++) rd_exp.push_back(conv_ref(i, taps, relu));
    axi_read(`EPU_OUT_BASE, 4'h5);
  endtask

  initial begin
    axi_pkg::addr_t base;
    axi_pkg::data_t v;
    int             len;
    int             idx;
    clk       = 1'b0;
    rst       = 1'b1;
    req       = '0;
    exp_push  = 1'b0;
    exp_data  = '0;
    exp_id    = '0;
    exp_last  = 1'b0;
    irq_check = 1'b0;
    irq_exp   = 1'b0;
    timeouts  = 0;
    lfsr      = 32'd94108;
    repeat (8) @(posedge clk);
    rst <= 1'b0;

    // Burst round trip through each buffer
    for (int r = 0; r < 3; r++) begin
      base = (r == 0) ? `EPU_IN_BASE : (r == 1) ? `EPU_WGT_BASE : `EPU_OUT_BASE;
      len  = 1 + int'(rand_bits(4));
      idx  = int'(rand_bits(8));
      wr_data.delete();
      for (int i = 0; i < len; i++) wr_data.push_back(rand_bits(32));
      rd_exp = wr_data;
      axi_write(base + axi_pkg::addr_t'(idx * 4), axi_pkg::id_t'(rand_bits(4)));
      axi_read(base + axi_pkg::addr_t'(idx * 4), axi_pkg::id_t'(rand_bits(4)));
    end

    // Word 255 is followed by word 0
    wr_data.delete();
    wr_data.push_back(rand_bits(32));
    wr_data.push_back(rand_bits(32));
    axi_write(`EPU_IN_BASE + 32'h3FC, 4'h6);
    rd_exp.delete();
    rd_exp.push_back(wr_data[1]);
    axi_read(`EPU_IN_BASE, 4'h7);
    rd_exp = wr_data;
    axi_read(`EPU_IN_BASE + 32'h3FC, 4'h8);
    rd_exp = '{32'd0, 32'd0, 32'd0, 32'd0};
    axi_read(32'h9000_0000, 4'h9);

    // Register block
    reg_read(`EPU_REG_STATUS, 32'd0);
    v = rand_bits(32);
    reg_write(`EPU_REG_LEN, v);
    reg_read(`EPU_REG_LEN, {24'd0, v[7:0]});
    v = rand_bits(32);
    reg_write(`EPU_REG_TAPS, v);
    reg_read(`EPU_REG_TAPS, {24'd0, v[7:0]});
    reg_write(`EPU_REG_CTRL, 32'h2);
    reg_read(`EPU_REG_CTRL, 32'h2);
    reg_write(`EPU_REG_CTRL, 32'h0);
    reg_read(`EPU_REG_CTRL, 32'h0);

    run_conv(1'b0);

    // ReLU run, then clear the done flag without a new start
    run_conv(1'b1);
    reg_read(`EPU_REG_STATUS, 32'h2);
    check_irq_level(1'b1);
    reg_write(`EPU_REG_CTRL, 32'h2);
    reg_read(`EPU_REG_STATUS, 32'h0);
    check_irq_level(1'b0);

    repeat (4) @(posedge clk);
    if (pending != 0) $display("%0d expected R beats never arrived", pending);
    $display("Summary: errors=%0d timeouts=%0d beats=%0d pending=%0d",
             err_cnt, timeouts, beat_cnt, pending);
    if (err_cnt == 0 && timeouts == 0 && pending == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- epu_top.f
+incdir+common
common/axi_pkg.sv
common/epu_pkg.sv
hdl/epu_slave_port.sv
hdl/epu_buffer.sv
hdl/epu_ctrl_regs.sv
conv_acc/conv_acc_engine.sv
hdl/epu_top.sv
tests/epu_checker.sv
tests/epu_tb.sv

//--- Makefile
# Verilator build and run for the EPU testbench

VERILATOR ?= verilator
TOP       ?= epu_tb
FILELIST  ?= epu_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= TEST PASS

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
